// ==== dv/pkt_dispatch_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module pkt_dispatch_sva (
  input logic logic_clk,
  input logic rst_n,
  input logic pkt_valid,
  input logic desc_valid,
  input logic pkt_drop
);

  desc_timing_a: assert property (@(posedge logic_clk) disable iff (!rst_n)
    desc_valid |-> $past(pkt_valid, 2))
    else $error("desc_valid without a frame two cycles earlier");

  drop_timing_a: assert property (@(posedge logic_clk) disable iff (!rst_n)
    pkt_drop |-> $past(pkt_valid))
    else $error("pkt_drop without a frame one cycle earlier");

  // same frame cannot be both dropped and described
  drop_or_desc_a: assert property (@(posedge logic_clk) disable iff (!rst_n)
    desc_valid |-> !$past(pkt_drop))
    else $error("frame was dropped and also produced a descriptor");

endmodule

bind pkt_dispatch pkt_dispatch_sva u_pkt_dispatch_sva (
  .logic_clk  (logic_clk),
  .rst_n      (rst_n),
  .pkt_valid  (pkt_valid),
  .desc_valid (desc_valid),
  .pkt_drop   (pkt_drop)
);

`default_nettype wire

// ==== dv/pkt_dispatch_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module pkt_dispatch_tb
  import dispatch_pkg::*;
  import mem_map_pkg::*;
();

  localparam slot_addr_t FIRST_SLOT_ADDR = 7'h40;
  localparam slot_addr_t SLOT_ADDR_STEP  = 7'h04;
  localparam int         TIMEOUT_CYCLES  = 2000;

  typedef struct packed {
    logic      desc;
    logic      drop;
    core_no_t  core;
    slot_no_t  slot;
    pkt_len_t  len;
    sys_addr_t addr;
  } outcome_t;

  logic                                    logic_clk;
  logic                                    rst_n;
  logic                                    pkt_valid;
  pkt_len_t                                pkt_len;
  logic [CORE_COUNT-1:0]                   core_msg_valid;
  logic [CORE_COUNT*$bits(core_msg_t)-1:0] core_msg_data;
  logic                                    desc_valid;
  core_no_t                                desc_core;
  slot_no_t                                desc_slot;
  pkt_len_t                                desc_len;
  sys_addr_t                               desc_addr;
  logic                                    pkt_drop;

  // reference model state
  slot_mask_t model_free [CORE_COUNT];
  core_no_t   model_next;
  outcome_t   stage1;
  outcome_t   stage2;

  logic [CORE_COUNT-1:0]                   msg_mask;
  logic [CORE_COUNT*$bits(core_msg_t)-1:0] msg_words;
  logic [31:0]                             lfsr = 32'h4f25d2c2;
  int                                      cycle_cnt = 0;

  pkt_dispatch #(
    .FIRST_SLOT_ADDR (FIRST_SLOT_ADDR),
    .SLOT_ADDR_STEP  (SLOT_ADDR_STEP)
  ) u_pkt_dispatch (
    .logic_clk      (logic_clk),
    .rst_n          (rst_n),
    .pkt_valid      (pkt_valid),
    .pkt_len        (pkt_len),
    .core_msg_valid (core_msg_valid),
    .core_msg_data  (core_msg_data),
    .desc_valid     (desc_valid),
    .desc_core      (desc_core),
    .desc_slot      (desc_slot),
    .desc_len       (desc_len),
    .desc_addr      (desc_addr),
    .pkt_drop       (pkt_drop)
  );

  initial begin
    logic_clk = 1'b0;
    forever #2 logic_clk = ~logic_clk;
  end

  always @(posedge logic_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not complete within %0d cycles", TIMEOUT_CYCLES);
      stop_with_failure();
    end
  end

  task automatic stop_with_failure();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic core_compare(string test, core_no_t exp, core_no_t act);
    if (act !== exp) begin
      $display("** Error [%s] desc_core expected %0d actual %0d", test, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic slot_compare(string test, slot_no_t exp, slot_no_t act);
    if (act !== exp) begin
      $display("** Error [%s] desc_slot expected %0d actual %0d", test, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic len_compare(string test, pkt_len_t exp, pkt_len_t act);
    if (act !== exp) begin
      $display("** Error [%s] desc_len expected %0h actual %0h", test, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic addr_compare(string test, sys_addr_t exp, sys_addr_t act);
    if (act !== exp) begin
      $display("** Error [%s] desc_addr expected %0h actual %0h", test, exp, act);
      stop_with_failure();
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_step();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic pkt_len_t random_len();
    pkt_len_t len;
    len = '0;
    for (int i = 0; i < $bits(pkt_len_t); i++)
      len = {len[$bits(pkt_len_t)-2:0], lfsr_step()};
    return len;
  endfunction

  // next core with a free slot, lowest slot, address from the memory map
  function automatic outcome_t model_frame(pkt_len_t len);
    outcome_t res;
    core_no_t idx;
    int       slot_idx;
    int       field;
    res      = '0;
    res.drop = 1'b1;
    for (int k = 0; k < CORE_COUNT; k++) begin
      idx = core_no_t'(int'(model_next) + k);
      if (res.drop && model_free[idx] != '0) begin
        res.drop = 1'b0;
        res.desc = 1'b1;
        res.core = idx;
      end
    end
    if (res.desc) begin
      slot_idx = 0;
      while (!model_free[res.core][slot_idx])
        slot_idx++;
      res.slot = slot_no_t'(slot_idx);
      model_free[res.core][res.slot] = 1'b0;
      model_next = core_no_t'(int'(res.core) + 1);
      res.len    = len;
      field      = (int'(FIRST_SLOT_ADDR) + int'(res.slot) * int'(SLOT_ADDR_STEP))
                   % (1 << $bits(slot_addr_t));
      res.addr   = sys_addr_t'(int'(res.core) * (1 << CORE_ADDR_WIDTH)
                   + field * (1 << SLOT_LEAD_ZERO));
    end
    return res;
  endfunction

  // driven at the next drive_cycle and applied to the model at once
  function automatic void post_message(core_no_t c, msg_kind_t kind, slot_no_t s);
    msg_mask[c] = 1'b1;
    msg_words[int'(c)*$bits(core_msg_t) +: $bits(core_msg_t)] =
      {kind, {($bits(core_msg_t)-$bits(msg_kind_t)-$bits(slot_no_t)){1'b0}}, s};
    if (kind == MSG_SLOT_RELEASE)
      model_free[c][s] = 1'b1;
  endfunction

  task automatic apply_reset();
    @(posedge logic_clk);
    rst_n          <= 1'b0;
    pkt_valid      <= 1'b0;
    core_msg_valid <= '0;
    repeat (2) @(posedge logic_clk);
    rst_n <= 1'b1;
    for (int c = 0; c < CORE_COUNT; c++)
      model_free[c] = '1;
    model_next = '0;
    stage1     = '0;
    stage2     = '0;
  endtask

  // drive one clock of inputs then check drop of the last frame and desc of the one before
  task automatic drive_cycle(string test, logic valid, pkt_len_t len);
    outcome_t fresh;
    @(posedge logic_clk);
    pkt_valid      <= valid;
    pkt_len        <= len;
    core_msg_valid <= msg_mask;
    core_msg_data  <= msg_words;
    msg_mask = '0;
    fresh    = '0;
    if (valid)
      fresh = model_frame(len);
    @(negedge logic_clk);
    if (pkt_drop !== stage1.drop) begin
      if (stage1.drop)
        $display("[%s] pkt_drop missing one cycle after a frame with no free slot", test);
      else
        $display("[%s] pkt_drop pulsed although no frame was dropped", test);
      stop_with_failure();
    end
    if (desc_valid !== stage2.desc) begin
      if (stage2.desc)
        $display("[%s] desc_valid missing two cycles after an accepted frame", test);
      else
        $display("[%s] desc_valid pulsed although no frame was accepted", test);
      stop_with_failure();
    end
    if (stage2.desc) begin
      core_compare(test, stage2.core, desc_core);
      slot_compare(test, stage2.slot, desc_slot);
      len_compare(test, stage2.len, desc_len);
      addr_compare(test, stage2.addr, desc_addr);
    end
    stage2 = stage1;
    stage1 = fresh;
  endtask

  task automatic first_frame_after_reset();
    string name = "first_frame_after_reset";
    repeat (3) drive_cycle(name, 1'b0, '0);
    drive_cycle(name, 1'b1, random_len());
    repeat (2) drive_cycle(name, 1'b0, '0);
  endtask

  task automatic back_to_back_frames();
    string name = "back_to_back_frames";
    apply_reset();
    repeat (CORE_COUNT*SLOT_COUNT) drive_cycle(name, 1'b1, random_len());
    repeat (2) drive_cycle(name, 1'b0, '0);
  endtask

  task automatic drop_when_full();
    string name = "drop_when_full";
    drive_cycle(name, 1'b1, random_len());
    repeat (2) drive_cycle(name, 1'b0, '0);
  endtask

  task automatic release_and_refill();
    string name = "release_and_refill";
    post_message(2'd2, MSG_SLOT_RELEASE, 2'd1);
    post_message(2'd0, MSG_SLOT_RELEASE, 2'd3);
    post_message(2'd3, MSG_SLOT_RELEASE, 2'd0);
    drive_cycle(name, 1'b0, '0);
    repeat (CORE_COUNT+2) drive_cycle(name, 1'b0, '0);
    // three refills, then one drop
    repeat (4) drive_cycle(name, 1'b1, random_len());
    repeat (2) drive_cycle(name, 1'b0, '0);
  endtask

  task automatic ignored_messages();
    string name = "ignored_messages";
    post_message(2'd1, MSG_SLOT_RELEASE, 2'd2);
    drive_cycle(name, 1'b0, '0);
    repeat (CORE_COUNT+2) drive_cycle(name, 1'b0, '0);
    // slot already free, and a kind that is not a release
    post_message(2'd1, MSG_SLOT_RELEASE, 2'd2);
    post_message(2'd0, msg_kind_t'(4'd2), 2'd1);
    drive_cycle(name, 1'b0, '0);
    repeat (CORE_COUNT+2) drive_cycle(name, 1'b0, '0);
    repeat (2) drive_cycle(name, 1'b1, random_len());
    repeat (2) drive_cycle(name, 1'b0, '0);
  endtask

  initial begin
    rst_n          = 1'b0;
    pkt_valid      = 1'b0;
    pkt_len        = '0;
    core_msg_valid = '0;
    core_msg_data  = '0;
    msg_mask       = '0;
    msg_words      = '0;
    apply_reset();
    first_frame_after_reset();
    back_to_back_frames();
    drop_when_full();
    release_and_refill();
    ignored_messages();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/alloc_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface alloc_if
  import dispatch_pkg::*;
();

  logic     valid;
  core_no_t core;
  slot_no_t slot;
  pkt_len_t len;

  // no back-pressure, every valid is taken
  modport tracker (output valid, core, slot, len);
  modport builder (input valid, core, slot, len);

endinterface

`default_nettype wire

// ==== hw/desc_builder.sv ====
`timescale 1ns/100ps
`default_nettype none

module desc_builder
  import dispatch_pkg::*;
  import mem_map_pkg::*;
#(
  parameter slot_addr_t FIRST_SLOT_ADDR = 7'h40,
  parameter slot_addr_t SLOT_ADDR_STEP  = 7'h04
)(
  input  logic      logic_clk,
  input  logic      rst_n,
  alloc_if.builder  alloc,
  output logic      desc_valid,
  output core_no_t  desc_core,
  output slot_no_t  desc_slot,
  output pkt_len_t  desc_len,
  output sys_addr_t desc_addr
);

  slot_addr_t slot_field;
  core_addr_t core_addr;

  assign slot_field = slot_addr_t'(FIRST_SLOT_ADDR + slot_addr_t'(alloc.slot) * SLOT_ADDR_STEP);

  // zero top bit, slot field, then the lead zeros
  assign core_addr = {1'b0, slot_field, {SLOT_LEAD_ZERO{1'b0}}};

  always_ff @(posedge logic_clk or negedge rst_n) begin
    if (!rst_n)
      desc_valid <= 1'b0;
    else
      desc_valid <= alloc.valid;
  end

  always_ff @(posedge logic_clk) begin
    if (alloc.valid) begin
      desc_core <= alloc.core;
      desc_slot <= alloc.slot;
      desc_len  <= alloc.len;
      desc_addr <= {alloc.core, core_addr};
    end
  end

endmodule

`default_nettype wire

// ==== hw/dispatch_pkg.sv ====
`default_nettype none

package dispatch_pkg;

  // design size
  localparam int CORE_COUNT = 4;
  localparam int SLOT_COUNT = 4;

  typedef logic [$clog2(CORE_COUNT)-1:0] core_no_t;
  typedef logic [$clog2(SLOT_COUNT)-1:0] slot_no_t;

  // one bit per slot, set when free
  typedef logic [SLOT_COUNT-1:0] slot_mask_t;

  typedef logic [15:0] pkt_len_t;

  // kind in the top nibble, slot number in the low bits
  typedef logic [63:0] core_msg_t;
  typedef logic [3:0]  msg_kind_t;

  localparam msg_kind_t MSG_SLOT_RELEASE = 4'd1;

endpackage

`default_nettype wire

// ==== hw/mem_map_pkg.sv ====
`default_nettype none

package mem_map_pkg;

  import dispatch_pkg::*;

  localparam int CORE_ADDR_WIDTH = 16;
  localparam int SLOT_LEAD_ZERO  = 8;

  // top bit of the core address stays zero
  typedef logic [CORE_ADDR_WIDTH-1-SLOT_LEAD_ZERO-1:0] slot_addr_t;
  typedef logic [CORE_ADDR_WIDTH-1:0]                  core_addr_t;

  // core number sits above the core address
  typedef logic [$bits(core_no_t)+CORE_ADDR_WIDTH-1:0] sys_addr_t;

endpackage

`default_nettype wire

// ==== hw/msg_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module msg_decode
  import dispatch_pkg::*;
(
  input  logic                            logic_clk,
  input  logic                            rst_n,
  input  logic      [CORE_COUNT-1:0]      core_msg_valid,
  input  core_msg_t [CORE_COUNT-1:0]      core_msg_data,
  output logic                            release_valid,
  output core_no_t                        release_core,
  output slot_no_t                        release_slot
);

  logic [CORE_COUNT-1:0] pend_valid;
  core_msg_t             pend_msg [CORE_COUNT];
  core_no_t              rr_ptr;

  logic      grant_found;
  core_no_t  grant_core;
  msg_kind_t grant_kind;

  // first pending core at or after the pointer
  always_comb begin
    core_no_t idx;
    grant_found = 1'b0;
    grant_core  = rr_ptr;
    for (int k = 0; k < CORE_COUNT; k++) begin
      idx = core_no_t'(rr_ptr + k);
      if (!grant_found && pend_valid[idx]) begin
        grant_found = 1'b1;
        grant_core  = idx;
      end
    end
  end

  assign grant_kind = pend_msg[grant_core][$bits(core_msg_t)-1 -: $bits(msg_kind_t)];

  always_ff @(posedge logic_clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_valid    <= '0;
      rr_ptr        <= '0;
      release_valid <= 1'b0;
    end else begin
      for (int c = 0; c < CORE_COUNT; c++) begin
        if (grant_found && grant_core == core_no_t'(c))
          pend_valid[c] <= 1'b0;
        if (core_msg_valid[c])
          pend_valid[c] <= 1'b1;
      end
      if (grant_found)
        rr_ptr <= grant_core + 1'b1;
      // other kinds are consumed without effect
      release_valid <= grant_found && (grant_kind == MSG_SLOT_RELEASE);
    end
  end

  always_ff @(posedge logic_clk) begin
    for (int c = 0; c < CORE_COUNT; c++) begin
      if (core_msg_valid[c])
        pend_msg[c] <= core_msg_data[c];
    end
    release_core <= grant_core;
    release_slot <= pend_msg[grant_core][$bits(slot_no_t)-1:0];
  end

endmodule

`default_nettype wire

// ==== hw/pkt_dispatch.sv ====
`timescale 1ns/100ps
`default_nettype none

module pkt_dispatch
  import dispatch_pkg::*;
  import mem_map_pkg::*;
#(
  parameter slot_addr_t FIRST_SLOT_ADDR = 7'h40,
  parameter slot_addr_t SLOT_ADDR_STEP  = 7'h04
)(
  input  logic                                  logic_clk,
  input  logic                                  rst_n,
  input  logic                                  pkt_valid,
  input  pkt_len_t                              pkt_len,
  input  logic [CORE_COUNT-1:0]                 core_msg_valid,
  input  logic [CORE_COUNT*$bits(core_msg_t)-1:0] core_msg_data,
  output logic                                  desc_valid,
  output core_no_t                              desc_core,
  output slot_no_t                              desc_slot,
  output pkt_len_t                              desc_len,
  output sys_addr_t                             desc_addr,
  output logic                                  pkt_drop
);

  logic     release_valid;
  core_no_t release_core;
  slot_no_t release_slot;

  alloc_if u_alloc ();

  msg_decode u_msg_decode (
    .logic_clk      (logic_clk),
    .rst_n          (rst_n),
    .core_msg_valid (core_msg_valid),
    .core_msg_data  (core_msg_data),
    .release_valid  (release_valid),
    .release_core   (release_core),
    .release_slot   (release_slot)
  );

  slot_tracker u_slot_tracker (
    .logic_clk     (logic_clk),
    .rst_n         (rst_n),
    .pkt_valid     (pkt_valid),
    .pkt_len       (pkt_len),
    .release_valid (release_valid),
    .release_core  (release_core),
    .release_slot  (release_slot),
    .pkt_drop      (pkt_drop),
    .alloc         (u_alloc.tracker)
  );

  desc_builder #(
    .FIRST_SLOT_ADDR (FIRST_SLOT_ADDR),
    .SLOT_ADDR_STEP  (SLOT_ADDR_STEP)
  ) u_desc_builder (
    .logic_clk  (logic_clk),
    .rst_n      (rst_n),
    .alloc      (u_alloc.builder),
    .desc_valid (desc_valid),
    .desc_core  (desc_core),
    .desc_slot  (desc_slot),
    .desc_len   (desc_len),
    .desc_addr  (desc_addr)
  );

endmodule

`default_nettype wire

// ==== hw/slot_tracker.sv ====
`timescale 1ns/100ps
`default_nettype none

module slot_tracker
  import dispatch_pkg::*;
(
  input  logic     logic_clk,
  input  logic     rst_n,
  input  logic     pkt_valid,
  input  pkt_len_t pkt_len,
  input  logic     release_valid,
  input  core_no_t release_core,
  input  slot_no_t release_slot,
  output logic     pkt_drop,
  alloc_if.tracker alloc
);

  slot_mask_t free_mask [CORE_COUNT];
  core_no_t   next_core;

  logic       pick_found;
  core_no_t   pick_core;
  slot_no_t   pick_slot;
  logic       take;

  always_comb begin
    core_no_t   idx;
    slot_mask_t pick_mask;
    pick_found = 1'b0;
    pick_core  = next_core;
    // round robin over cores with any free slot
    for (int k = 0; k < CORE_COUNT; k++) begin
      idx = core_no_t'(next_core + k);
      if (!pick_found && |free_mask[idx]) begin
        pick_found = 1'b1;
        pick_core  = idx;
      end
    end
    // lowest free slot of that core
    pick_mask = free_mask[pick_core];
    pick_slot = '0;
    for (int s = SLOT_COUNT-1; s >= 0; s--) begin
      if (pick_mask[s])
        pick_slot = slot_no_t'(s);
    end
  end

  assign take = pkt_valid && pick_found;

  always_ff @(posedge logic_clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int c = 0; c < CORE_COUNT; c++)
        free_mask[c] <= '1;
      next_core   <= '0;
      alloc.valid <= 1'b0;
      pkt_drop    <= 1'b0;
    end else begin
      for (int c = 0; c < CORE_COUNT; c++) begin
        if (release_valid && release_core == core_no_t'(c))
          free_mask[c][release_slot] <= 1'b1;
        // allocation sees the mask from before a same-cycle release
        if (take && pick_core == core_no_t'(c))
          free_mask[c][pick_slot] <= 1'b0;
      end
      if (take)
        next_core <= pick_core + 1'b1;
      alloc.valid <= take;
      pkt_drop    <= pkt_valid && !pick_found;
    end
  end

  always_ff @(posedge logic_clk) begin
    if (pkt_valid) begin
      alloc.core <= pick_core;
      alloc.slot <= pick_slot;
      alloc.len  <= pkt_len;
    end
  end

endmodule

`default_nettype wire

// ==== pkt_dispatch.f ====
hw/dispatch_pkg.sv
hw/mem_map_pkg.sv
hw/alloc_if.sv
hw/msg_decode.sv
hw/slot_tracker.sv
hw/desc_builder.sv
hw/pkt_dispatch.sv
dv/pkt_dispatch_sva.sv
dv/pkt_dispatch_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the pkt_dispatch testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module pkt_dispatch_tb \
  -f pkt_dispatch.f -Mdir obj_dir -o pkt_dispatch_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/pkt_dispatch_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi

exit 0
